// File: all.f
+incdir+.
core_pkg.sv
exec_if.sv
instr_fetch.sv
data_stack.sv
stack_alu.sv
execute_unit.sv
result_port.sv
stack_core.sv
tb_stack_core.sv

// File: core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef logic [`CORE_WORD_WIDTH-1:0] word_t;

  typedef logic [`CORE_PROG_ADDR_WIDTH-1:0] prog_addr_t;

  // Operations encoded in the low seven bits of a byte with the MSB clear
  typedef enum logic [6:0] {
    OP_NOP  = 7'h00,
    OP_DUP  = 7'h01,
    OP_DROP = 7'h02,
    OP_SWAP = 7'h03,
    OP_ADD  = 7'h04,
    OP_ADC  = 7'h05,
    OP_SUB  = 7'h06,
    OP_AND  = 7'h07,
    OP_OR   = 7'h08,
    OP_XOR  = 7'h09,
    OP_JMP  = 7'h0a,
    OP_JZ   = 7'h0b,
    OP_CALL = 7'h0c,
    OP_RET  = 7'h0d,
    OP_OUT  = 7'h0e,
    OP_HALT = 7'h0f
  } opcode_e;

  typedef struct packed {
    logic    is_imm;
    opcode_e code;
  } op_fields_t;

  typedef struct packed {
    logic       is_imm;
    logic [6:0] value;
  } imm_fields_t;

  // One program byte, read as an opcode or as a short immediate by its MSB
  typedef union packed {
    op_fields_t  op;
    imm_fields_t imm;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

endpackage

// File: core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of one data word on the stack and at the output port
`define CORE_WORD_WIDTH 32

// Program memory holds 2**CORE_PROG_ADDR_WIDTH bytes
`define CORE_PROG_ADDR_WIDTH 8

// Total entries of the data stack, top and second included
`define CORE_DSTACK_DEPTH 16

// Nesting depth of CALL
`define CORE_CSTACK_DEPTH 4

// Words the receiver can accept before it returns a credit
`define CORE_OUT_CREDITS 4

`endif

// File: data_stack.sv
`timescale 1ns/1ns
`include "core_settings.svh"

// Top and second live in registers so both are readable in the same cycle.
// pop removes one word and replace_two removes two. replace_top then writes
// next_top over whatever word is on top after the removal
module data_stack
  import core_pkg::*;
#(
  parameter int DEPTH = `CORE_DSTACK_DEPTH
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  push,
  input  logic  pop,
  input  logic  replace_top,
  input  logic  replace_two,
  input  logic  swap,
  input  word_t next_top,
  output word_t top,
  output word_t second
);

  localparam int SPILL_DEPTH = DEPTH - 2;
  localparam int CW = $clog2(DEPTH + 1);
  localparam int AW = $clog2(SPILL_DEPTH);

  word_t         spill [SPILL_DEPTH];
  logic [CW-1:0] count;
  word_t         deep1;
  word_t         deep2;

  // Entry three sits at spill[0]
  assign deep1 = (count >= CW'(3)) ? spill[AW'(count - CW'(3))] : '0;
  assign deep2 = (count >= CW'(4)) ? spill[AW'(count - CW'(4))] : '0;

  always_ff @(posedge clk) begin
    if (push) begin
      top <= next_top;
      second <= top;
      if (count >= CW'(2)) begin
        spill[AW'(count - CW'(2))] <= second;
      end
    end else if (replace_two) begin
      top <= replace_top ? next_top : deep1;
      second <= deep2;
    end else if (pop) begin
      top <= replace_top ? next_top : second;
      second <= deep1;
    end else if (swap) begin
      top <= second;
      second <= top;
    end else if (replace_top) begin
      top <= next_top;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push) begin
      count <= count + CW'(1);
    end else if (replace_two) begin
      count <= count - CW'(2);
    end else if (pop) begin
      count <= count - CW'(1);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count != CW'(DEPTH))
    else $error("data stack overflow");

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    (replace_two |-> count >= CW'(2)) and (pop |-> count >= CW'(1)))
    else $error("data stack underflow");

endmodule

// File: exec_if.sv
`timescale 1ns/1ns
`include "core_settings.svh"

// Decoded work flows from fetch to execute, the two top stack words flow back
interface exec_if
  import core_pkg::*;
();

  logic    fire;
  opcode_e op;
  logic    push_imm;
  word_t   imm;
  word_t   top;
  word_t   second;

  modport fetch (
    output fire,
    output op,
    output push_imm,
    output imm,
    input  top,
    input  second
  );

  modport exec (
    input  fire,
    input  op,
    input  push_imm,
    input  imm,
    output top,
    output second
  );

endinterface

// File: execute_unit.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module execute_unit
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  exec_if.exec  ex,
  output word_t out_word
);

  logic    push;
  logic    pop;
  logic    replace_top;
  logic    replace_two;
  logic    swap;
  logic    store_carry;
  logic    carry;
  logic    carry_out;
  word_t   next_top;
  word_t   top;
  word_t   second;
  word_t   alu_result;
  alu_op_e alu_op;

  // One stack movement per fired instruction
  always_comb begin
    push = 1'b0;
    pop = 1'b0;
    replace_top = 1'b0;
    replace_two = 1'b0;
    swap = 1'b0;
    store_carry = 1'b0;
    next_top = alu_result;
    alu_op = ALU_ADD;
    if (ex.fire) begin
      if (ex.push_imm) begin
        push = 1'b1;
        next_top = ex.imm;
      end else begin
        case (ex.op)
          OP_DUP: begin
            push = 1'b1;
            next_top = top;
          end
          OP_DROP,
          OP_JMP,
          OP_CALL,
          OP_OUT:  pop = 1'b1;
          OP_SWAP: swap = 1'b1;
          // Address and condition both leave
          OP_JZ:   replace_two = 1'b1;
          OP_ADD,
          OP_ADC,
          OP_SUB: begin
            pop = 1'b1;
            replace_top = 1'b1;
            store_carry = 1'b1;
            alu_op = (ex.op == OP_ADC) ? ALU_ADC : (ex.op == OP_SUB) ? ALU_SUB : ALU_ADD;
          end
          OP_AND,
          OP_OR,
          OP_XOR: begin
            pop = 1'b1;
            replace_top = 1'b1;
            alu_op = (ex.op == OP_AND) ? ALU_AND : (ex.op == OP_OR) ? ALU_OR : ALU_XOR;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      carry <= 1'b0;
    end else if (store_carry) begin
      carry <= carry_out;
    end
  end

  data_stack u_dstack (
    .clk         (clk),
    .reset       (reset),
    .push        (push),
    .pop         (pop),
    .replace_top (replace_top),
    .replace_two (replace_two),
    .swap        (swap),
    .next_top    (next_top),
    .top         (top),
    .second      (second)
  );

  stack_alu u_alu (
    .op        (alu_op),
    .a         (second),
    .b         (top),
    .carry_in  (carry),
    .result    (alu_result),
    .carry_out (carry_out)
  );

  assign ex.top = top;
  assign ex.second = second;
  assign out_word = top;

endmodule

// File: instr_fetch.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module instr_fetch
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  logic       prog_we,
  input  prog_addr_t prog_addr,
  input  logic [7:0] prog_data,
  input  logic       stall,
  output logic       out_req,
  output logic       halted,
  exec_if.fetch      ex
);

  localparam int PROG_SIZE = 1 << `CORE_PROG_ADDR_WIDTH;
  localparam int CS_DEPTH = `CORE_CSTACK_DEPTH;
  localparam int CS_PW = $clog2(CS_DEPTH + 1);
  localparam int CS_AW = $clog2(CS_DEPTH);

  logic [7:0]       prog_mem [PROG_SIZE];
  prog_addr_t       cs_mem [CS_DEPTH];
  logic [CS_PW-1:0] cs_ptr;
  prog_addr_t       cs_top;
  prog_addr_t       pc;
  prog_addr_t       pc_inc;
  prog_addr_t       pc_next;
  prog_addr_t       jump_addr;
  instr_u           instr;
  logic             active;
  logic             is_op;
  logic             do_call;
  logic             do_ret;

  always_ff @(posedge clk) begin
    if (prog_we) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  assign instr = prog_mem[pc];
  assign is_op = !instr.op.is_imm;
  assign active = run && !halted;

  assign ex.fire = active && !stall;
  assign ex.op = instr.op.code;
  assign ex.push_imm = instr.imm.is_imm;
  assign ex.imm = word_t'(instr.imm.value);

  // OUT asks for a credit before it may fire
  assign out_req = active && is_op && instr.op.code == OP_OUT;

  assign pc_inc = pc + 1'b1;
  assign jump_addr = ex.top[`CORE_PROG_ADDR_WIDTH-1:0];
  assign cs_top = cs_mem[CS_AW'(cs_ptr - 1'b1)];

  assign do_call = ex.fire && is_op && instr.op.code == OP_CALL;
  assign do_ret = ex.fire && is_op && instr.op.code == OP_RET;

  always_comb begin
    pc_next = pc_inc;
    if (is_op) begin
      case (instr.op.code)
        OP_JMP,
        OP_CALL: pc_next = jump_addr;
        // Condition sits under the address
        OP_JZ:   pc_next = (ex.second == '0) ? jump_addr : pc_inc;
        OP_RET:  pc_next = cs_top;
        OP_HALT: pc_next = pc;
        default: pc_next = pc_inc;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_call) begin
      cs_mem[CS_AW'(cs_ptr)] <= pc_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      cs_ptr <= '0;
      halted <= 1'b0;
    end else if (ex.fire) begin
      pc <= pc_next;
      if (do_call) begin
        cs_ptr <= cs_ptr + 1'b1;
      end else if (do_ret) begin
        cs_ptr <= cs_ptr - 1'b1;
      end
      if (is_op && instr.op.code == OP_HALT) begin
        halted <= 1'b1;
      end
    end
  end

  // Loading and running share the program memory port
  a_load_idle: assert property (@(posedge clk) disable iff (reset) !(prog_we && run))
    else $error("program write while running");

  a_call_depth: assert property (@(posedge clk) disable iff (reset)
    do_call |-> cs_ptr != CS_PW'(CS_DEPTH))
    else $error("call stack overflow");

  a_ret_depth: assert property (@(posedge clk) disable iff (reset) do_ret |-> cs_ptr != '0)
    else $error("call stack underflow");

endmodule

// File: result_port.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module result_port
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  out_req,
  input  word_t out_word,
  input  logic  out_credit,
  output logic  stall,
  output logic  out_valid,
  output word_t out_data
);

  localparam int CW = $clog2(`CORE_OUT_CREDITS + 1);

  logic [CW-1:0] credits;
  logic [CW-1:0] credits_next;
  logic          send;

  // Without a credit the OUT holds and retries next cycle
  assign stall = out_req && credits == '0;
  assign send = out_req && !stall;

  // A credit is spent at the edge that launches the word
  assign credits_next = credits - CW'(send) + CW'(out_credit);

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CW'(`CORE_OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      credits <= credits_next;
      out_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_data <= out_word;
    end
  end

  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credits <= CW'(`CORE_OUT_CREDITS))
    else $error("receiver returned more credits than words");

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stack_core -f all.f -o sim_stack_core

out=$(./obj_dir/sim_stack_core)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: stack_alu.sv
`timescale 1ns/1ns
`include "core_settings.svh"

// a is second and b is top, so SUB gives second minus top
module stack_alu
  import core_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  logic    carry_in,
  output word_t   result,
  output logic    carry_out
);

  localparam int W = `CORE_WORD_WIDTH;

  logic [W:0] wide;
  logic [W:0] a_ext;
  logic [W:0] b_ext;
  logic [W:0] c_ext;

  assign a_ext = {1'b0, a};
  assign b_ext = {1'b0, b};
  assign c_ext = {{W{1'b0}}, carry_in};

  // The extra bit holds the carry, or the borrow when subtracting
  always_comb begin
    case (op)
      ALU_ADD: wide = a_ext + b_ext;
      ALU_ADC: wide = a_ext + b_ext + c_ext;
      ALU_SUB: wide = a_ext - b_ext;
      ALU_AND: wide = a_ext & b_ext;
      ALU_OR:  wide = a_ext | b_ext;
      ALU_XOR: wide = a_ext ^ b_ext;
      default: wide = '0;
    endcase
  end

  assign result = wide[W-1:0];
  assign carry_out = wide[W];

endmodule

// File: stack_core.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module stack_core
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  logic       prog_we,
  input  prog_addr_t prog_addr,
  input  logic [7:0] prog_data,
  input  logic       out_credit,
  output logic       out_valid,
  output word_t      out_data,
  output logic       halted
);

  logic  out_req;
  logic  stall;
  word_t out_word;

  exec_if ex ();

  instr_fetch u_fetch (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .stall     (stall),
    .out_req   (out_req),
    .halted    (halted),
    .ex        (ex)
  );

  execute_unit u_exec (
    .clk      (clk),
    .reset    (reset),
    .ex       (ex),
    .out_word (out_word)
  );

  // Word and request meet here in the same cycle the OUT would fire
  result_port u_out (
    .clk        (clk),
    .reset      (reset),
    .out_req    (out_req),
    .out_word   (out_word),
    .out_credit (out_credit),
    .stall      (stall),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

// File: tb_stack_core.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_stack_core
  import core_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS = 6;
  localparam int MAX_BYTES = 40;
  localparam int MAX_WORDS = 12;
  localparam int SETTLE_CYCLES = 16;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 400;

  logic       clk;
  logic       reset;
  logic       run;
  logic       prog_we;
  prog_addr_t prog_addr;
  logic [7:0] prog_data;
  logic       out_credit;
  logic       out_valid;
  word_t      out_data;
  logic       halted;

  // Test table, one row per program
  string      test_name [NUM_TESTS];
  logic [7:0] prog_bytes [NUM_TESTS][MAX_BYTES];
  int         prog_len [NUM_TESTS];
  word_t      exp_words [NUM_TESTS][MAX_WORDS];
  int         exp_len [NUM_TESTS];
  bit         random_credit [NUM_TESTS];

  word_t got [$];
  int    check_errors;
  int    pass_count;
  int    fail_count;
  bit    credit_random;

  stack_core DUT (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic append_byte(input int t, input logic [7:0] b);
    prog_bytes[t][prog_len[t]] = b;
    prog_len[t]++;
  endtask

  // Opcode bytes have the MSB clear, immediates have it set
  task automatic code_op(input int t, input opcode_e code);
    append_byte(t, {1'b0, code});
  endtask

  task automatic code_imm(input int t, input logic [6:0] value);
    append_byte(t, {1'b1, value});
  endtask

  task automatic pad_to(input int t, input int addr);
    while (prog_len[t] < addr) begin
      code_op(t, OP_NOP);
    end
  endtask

  task automatic expect_word(input int t, input word_t w);
    exp_words[t][exp_len[t]] = w;
    exp_len[t]++;
  endtask

  task automatic build_table();
    int k;
    for (k = 0; k < NUM_TESTS; k++) begin
      prog_len[k] = 0;
      exp_len[k] = 0;
      random_credit[k] = 1'b0;
    end

    test_name[0] = "stack_and_logic";
    code_imm(0, 7'd5);
    code_imm(0, 7'd7);
    code_op(0, OP_SWAP);
    code_op(0, OP_OUT);
    code_op(0, OP_DUP);
    code_op(0, OP_OUT);
    code_imm(0, 7'h0c);
    code_op(0, OP_AND);
    code_op(0, OP_OUT);
    code_imm(0, 7'h33);
    code_imm(0, 7'h0f);
    code_op(0, OP_OR);
    code_op(0, OP_OUT);
    code_imm(0, 7'h55);
    code_imm(0, 7'h0f);
    code_op(0, OP_XOR);
    code_op(0, OP_OUT);
    code_imm(0, 7'd9);
    code_imm(0, 7'd8);
    code_op(0, OP_DROP);
    code_op(0, OP_OUT);
    code_imm(0, 7'h7f);
    code_op(0, OP_OUT);
    code_op(0, OP_HALT);
    expect_word(0, 32'd5);
    expect_word(0, 32'd7);
    expect_word(0, 32'd4);
    expect_word(0, 32'h3f);
    expect_word(0, 32'h5a);
    expect_word(0, 32'd9);
    expect_word(0, 32'h7f);

    // 0 - 1 gives all ones, adding 0 clears the carry, adding 1 overflows
    test_name[1] = "carry_chain";
    code_imm(1, 7'd0);
    code_imm(1, 7'd1);
    code_op(1, OP_SUB);
    code_imm(1, 7'd0);
    code_op(1, OP_ADD);
    code_imm(1, 7'd1);
    code_op(1, OP_ADD);
    code_op(1, OP_OUT);
    code_imm(1, 7'd5);
    code_imm(1, 7'd6);
    code_op(1, OP_ADC);
    code_op(1, OP_OUT);
    code_imm(1, 7'd3);
    code_imm(1, 7'd5);
    code_op(1, OP_SUB);
    code_op(1, OP_OUT);
    code_imm(1, 7'd10);
    code_imm(1, 7'd20);
    code_op(1, OP_ADC);
    code_op(1, OP_OUT);
    code_imm(1, 7'd1);
    code_imm(1, 7'd2);
    code_op(1, OP_ADC);
    code_op(1, OP_OUT);
    code_op(1, OP_HALT);
    expect_word(1, 32'h0000_0000);
    expect_word(1, 32'd12);
    expect_word(1, 32'hffff_fffe);
    expect_word(1, 32'd31);
    expect_word(1, 32'd3);

    test_name[2] = "jumps";
    code_imm(2, 7'd4);
    code_op(2, OP_JMP);
    code_imm(2, 7'h11);
    code_op(2, OP_OUT);
    code_imm(2, 7'd0);
    code_imm(2, 7'd9);
    code_op(2, OP_JZ);
    code_imm(2, 7'h22);
    code_op(2, OP_OUT);
    code_imm(2, 7'd1);
    code_imm(2, 7'h7f);
    code_op(2, OP_JZ);
    code_imm(2, 7'h33);
    code_op(2, OP_OUT);
    code_imm(2, 7'h44);
    code_op(2, OP_OUT);
    code_op(2, OP_HALT);
    expect_word(2, 32'h33);
    expect_word(2, 32'h44);

    // Main calls A at 20, then B at 30, and B calls A again
    test_name[3] = "nested_calls";
    random_credit[3] = 1'b1;
    code_imm(3, 7'd20);
    code_op(3, OP_CALL);
    code_imm(3, 7'h01);
    code_op(3, OP_OUT);
    code_imm(3, 7'd30);
    code_op(3, OP_CALL);
    code_imm(3, 7'h03);
    code_op(3, OP_OUT);
    code_op(3, OP_HALT);
    pad_to(3, 20);
    code_imm(3, 7'h0a);
    code_op(3, OP_OUT);
    code_op(3, OP_RET);
    pad_to(3, 30);
    code_imm(3, 7'h0b);
    code_op(3, OP_OUT);
    code_imm(3, 7'd20);
    code_op(3, OP_CALL);
    code_imm(3, 7'h0c);
    code_op(3, OP_OUT);
    code_op(3, OP_RET);
    expect_word(3, 32'h0a);
    expect_word(3, 32'h01);
    expect_word(3, 32'h0b);
    expect_word(3, 32'h0a);
    expect_word(3, 32'h0c);
    expect_word(3, 32'h03);

    // Ten back-to-back OUTs run the credits dry
    test_name[4] = "credit_backpressure";
    random_credit[4] = 1'b1;
    for (k = 1; k <= 10; k++) begin
      code_imm(4, 7'(k));
    end
    for (k = 10; k >= 1; k--) begin
      code_op(4, OP_OUT);
      expect_word(4, word_t'(k));
    end
    code_op(4, OP_HALT);

    test_name[5] = "halt_stops";
    code_imm(5, 7'h15);
    code_op(5, OP_OUT);
    code_op(5, OP_HALT);
    code_imm(5, 7'h16);
    code_op(5, OP_OUT);
    code_imm(5, 7'h17);
    code_op(5, OP_OUT);
    expect_word(5, 32'h15);
  endtask

  // Receiver model that collects words and returns one credit per word
  initial begin
    int          cycle;
    int          last_due;
    int          next_due;
    int          outstanding;
    int          due [$];
    int unsigned delay;
    void'($urandom(56));
    out_credit = 1'b0;
    cycle = 0;
    last_due = 0;
    outstanding = 0;
    forever begin
      @(negedge clk);
      cycle++;
      if (reset) begin
        got.delete();
        due.delete();
        outstanding = 0;
        last_due = cycle;
        out_credit = 1'b0;
      end else begin
        out_credit = 1'b0;
        if (out_valid) begin
          got.push_back(out_data);
          outstanding++;
          assert (outstanding <= `CORE_OUT_CREDITS) else begin
            $display("more than %0d words outstanding at the receiver", `CORE_OUT_CREDITS);
            check_errors++;
          end
          delay = credit_random ? $urandom % 8 : 0;
          next_due = cycle + int'(delay);
          if (next_due <= last_due) begin
            next_due = last_due + 1;
          end
          last_due = next_due;
          due.push_back(next_due);
        end
        if (due.size() > 0 && due[0] <= cycle) begin
          void'(due.pop_front());
          out_credit = 1'b1;
          outstanding--;
        end
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    run = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic load_program(input int t);
    int i;
    for (i = 0; i < prog_len[t]; i++) begin
      @(negedge clk);
      prog_we = 1'b1;
      prog_addr = prog_addr_t'(i);
      prog_data = prog_bytes[t][i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic run_test(input int t);
    int errs_before;
    int i;
    apply_reset();
    errs_before = check_errors;
    credit_random = random_credit[t];
    load_program(t);
    @(negedge clk);
    run = 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    // Halted must hold while later bytes stay unexecuted
    repeat (SETTLE_CYCLES) begin
      @(negedge clk);
      assert (halted) else begin
        $display("%s: halted dropped after HALT", test_name[t]);
        check_errors++;
      end
    end
    @(posedge clk);
    for (i = 0; i < exp_len[t] && i < got.size(); i++) begin
      assert (got[i] === exp_words[t][i]) else begin
        $display("[FAIL] %s word %0d: expected %h, actual %h",
                 test_name[t], i, exp_words[t][i], got[i]);
        check_errors++;
      end
    end
    assert (got.size() == exp_len[t]) else begin
      $display("%s: received %0d output words but expected %0d",
               test_name[t], got.size(), exp_len[t]);
      check_errors++;
    end
    @(negedge clk);
    run = 1'b0;
    if (check_errors == errs_before) begin
      pass_count++;
      $display("test %s: passed", test_name[t]);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", test_name[t], check_errors - errs_before);
    end
  endtask

  initial begin
    int t;
    reset = 1'b1;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    credit_random = 1'b0;
    check_errors = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, pass_count, fail_count);
    if (fail_count == 0 && check_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests completed");
    $display("sim failed");
    $finish;
  end

endmodule
